/* source/harness_pkg.sv */
package harness_pkg;

  // UART bit period in clk cycles
  localparam int CLKS_PER_BIT = 8;
  localparam int BIT_CNT_W = $clog2(CLKS_PER_BIT);

  localparam int CMD_W = 32;

  // Program memory, word addressed
  localparam int MEM_ADDR_W = 12;
  localparam int MEM_WORDS = 1 << MEM_ADDR_W;

  // Core reset release delay
  localparam int RELEASE_CYCLES = 16;
  localparam int REL_CNT_W = $clog2(RELEASE_CYCLES + 1);

  typedef enum logic [3:0] {
    OP_WRITE_LO     = 4'h1,
    OP_WRITE_HI     = 4'h2,
    OP_READ         = 4'h3,
    OP_HOLD_CORE    = 4'h4,
    OP_RELEASE_CORE = 4'h5
  } cmd_op_e;

  // Command layout, MSB first
  typedef struct packed {
    cmd_op_e               op;
    logic [MEM_ADDR_W-1:0] addr;
    logic [15:0]           imm;
  } cmd_fields_t;

  // Receivers fill raw, the controller reads f
  typedef union packed {
    logic [CMD_W-1:0] raw;
    cmd_fields_t      f;
  } cmd_word_u;

  typedef struct packed {
    logic      valid;
    cmd_word_u word;
  } cmd_strobe_t;

  // Half-word write into program memory
  typedef struct packed {
    logic                  valid;
    logic [MEM_ADDR_W-1:0] addr;
    logic                  hi;
    logic [15:0]           data16;
  } mem_wr_t;

  // Wishbone classic, core side
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [31:0] addr;
    logic [31:0] wdata;
  } wb_req_t;

  typedef struct packed {
    logic        ack;
    logic [31:0] rdata;
  } wb_rsp_t;

endpackage

/* source/uart_cmd_rx.sv */
`timescale 1ns/1ps

module uart_cmd_rx (
  input  logic                     clk,
  input  logic                     reset_i,
  input  logic                     rx_i,
  output harness_pkg::cmd_strobe_t cmd_o
);

  import harness_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_START,
    S_DATA,
    S_STOP
  } state_e;

  state_e               state_q;
  logic                 rx_meta_q;
  logic                 rx_q;
  logic [BIT_CNT_W-1:0] clk_cnt_q;
  logic [2:0]           bit_cnt_q;
  logic [1:0]           byte_cnt_q;
  logic [7:0]           byte_q;
  logic [23:0]          low_bytes_q;
  logic                 tick;
  logic                 sample_bit;
  logic                 byte_done;

  // Line idles high
  always_ff @(posedge clk) begin
    if (reset_i) begin
      rx_meta_q <= 1'b1;
      rx_q      <= 1'b1;
    end else begin
      rx_meta_q <= rx_i;
      rx_q      <= rx_meta_q;
    end
  end

  assign tick       = (clk_cnt_q == BIT_CNT_W'(CLKS_PER_BIT - 1));
  assign sample_bit = (state_q == S_DATA) && tick;
  assign byte_done  = (state_q == S_STOP) && tick && rx_q;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q    <= S_IDLE;
      clk_cnt_q  <= '0;
      bit_cnt_q  <= '0;
      byte_cnt_q <= '0;
    end else begin
      case (state_q)
        S_IDLE: begin
          clk_cnt_q <= '0;
          bit_cnt_q <= '0;
          if (!rx_q) state_q <= S_START;
        end
        S_START: begin
          // Recheck the start bit at its middle
          if (clk_cnt_q == BIT_CNT_W'(CLKS_PER_BIT / 2 - 1)) begin
            clk_cnt_q <= '0;
            state_q   <= rx_q ? S_IDLE : S_DATA;
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
        S_DATA: begin
          clk_cnt_q <= tick ? '0 : clk_cnt_q + 1'b1;
          if (tick) begin
            bit_cnt_q <= bit_cnt_q + 1'b1;
            if (bit_cnt_q == 3'd7) state_q <= S_STOP;
          end
        end
        default: begin
          clk_cnt_q <= tick ? '0 : clk_cnt_q + 1'b1;
          if (tick) begin
            state_q <= S_IDLE;
            // Framing error drops the partial word
            byte_cnt_q <= rx_q ? byte_cnt_q + 1'b1 : 2'd0;
          end
        end
      endcase
    end
  end

  // Bytes arrive LSB first, least significant byte first
  always_ff @(posedge clk) begin
    if (sample_bit) byte_q <= {rx_q, byte_q[7:1]};
    if (byte_done) low_bytes_q <= {byte_q, low_bytes_q[23:8]};
    if (byte_done) cmd_o.word.raw <= {byte_q, low_bytes_q};
    cmd_o.valid <= byte_done && (byte_cnt_q == 2'd3);
    if (reset_i) cmd_o.valid <= 1'b0;
  end

endmodule

/* source/spi_cmd_rx.sv */
`timescale 1ns/1ps

module spi_cmd_rx (
  input  logic                     clk,
  input  logic                     reset_i,
  input  logic                     sck_i,
  input  logic                     cs_i,
  input  logic                     mosi_i,
  input  logic [31:0]              read_data_i,
  output logic                     miso_o,
  output harness_pkg::cmd_strobe_t cmd_o
);

  import harness_pkg::*;

  // Two sync stages plus one delayed copy for edge detection
  logic [2:0]       sck_sr_q;
  logic [2:0]       cs_sr_q;
  logic [1:0]       mosi_sr_q;
  logic [5:0]       bit_cnt_q;
  logic [CMD_W-1:0] shift_in_q;
  logic [31:0]      shift_out_q;
  logic             cs_act;
  logic             sck_rise;
  logic             sck_fall;
  logic             cs_fall;
  logic             cs_rise;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      sck_sr_q  <= 3'b000;
      cs_sr_q   <= 3'b111;
      mosi_sr_q <= 2'b00;
    end else begin
      sck_sr_q  <= {sck_sr_q[1:0], sck_i};
      cs_sr_q   <= {cs_sr_q[1:0], cs_i};
      mosi_sr_q <= {mosi_sr_q[0], mosi_i};
    end
  end

  assign cs_act   = !cs_sr_q[1];
  assign sck_rise = sck_sr_q[1] && !sck_sr_q[2];
  assign sck_fall = !sck_sr_q[1] && sck_sr_q[2];
  assign cs_fall  = !cs_sr_q[1] && cs_sr_q[2];
  assign cs_rise  = cs_sr_q[1] && !cs_sr_q[2];

  // Saturating bit count, only a clean 32-bit frame is a command
  always_ff @(posedge clk) begin
    if (reset_i || cs_fall) begin
      bit_cnt_q <= '0;
    end else if (cs_act && sck_rise && bit_cnt_q != 6'd63) begin
      bit_cnt_q <= bit_cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (cs_act && sck_rise) shift_in_q <= {shift_in_q[CMD_W-2:0], mosi_sr_q[1]};
    // MISO MSB is ready before the first rising sck
    if (cs_fall) begin
      shift_out_q <= read_data_i;
    end else if (cs_act && sck_fall) begin
      shift_out_q <= {shift_out_q[30:0], 1'b0};
    end
  end

  assign miso_o = shift_out_q[31];

  always_ff @(posedge clk) begin
    if (cs_rise) cmd_o.word.raw <= shift_in_q;
    cmd_o.valid <= cs_rise && (bit_cnt_q == 6'd32);
    if (reset_i) cmd_o.valid <= 1'b0;
  end

endmodule

/* source/cmd_controller.sv */
`timescale 1ns/1ps

module cmd_controller (
  input  logic                               clk,
  input  logic                               reset_i,
  input  harness_pkg::cmd_strobe_t           uart_cmd_i,
  input  harness_pkg::cmd_strobe_t           spi_cmd_i,
  input  logic                               core_reset_i,
  output harness_pkg::mem_wr_t               mem_wr_o,
  output logic                               rd_en_o,
  output logic [harness_pkg::MEM_ADDR_W-1:0] rd_addr_o,
  input  logic [31:0]                        rd_data_i,
  output logic [31:0]                        read_data_o,
  output logic                               hold_o,
  output logic                               release_o
);

  import harness_pkg::*;

  cmd_strobe_t pend_q;
  cmd_strobe_t cur_cmd;
  mem_wr_t     wr_d;
  mem_wr_t     wr_q;
  logic        rd_pend_q;

  // UART first, then the parked SPI word, then a fresh SPI word
  always_comb begin
    if (uart_cmd_i.valid) begin
      cur_cmd = uart_cmd_i;
    end else if (pend_q.valid) begin
      cur_cmd = pend_q;
    end else begin
      cur_cmd = spi_cmd_i;
    end
  end

  // SPI word waits one cycle when the UART takes the slot
  always_ff @(posedge clk) begin
    if (spi_cmd_i.valid) pend_q.word <= spi_cmd_i.word;
    pend_q.valid <= (pend_q.valid && uart_cmd_i.valid) ||
                    (spi_cmd_i.valid && (uart_cmd_i.valid || pend_q.valid));
    if (reset_i) pend_q.valid <= 1'b0;
  end

  always_comb begin
    wr_d        = '0;
    wr_d.addr   = cur_cmd.word.f.addr;
    wr_d.data16 = cur_cmd.word.f.imm;
    rd_addr_o   = cur_cmd.word.f.addr;
    rd_en_o     = 1'b0;
    hold_o      = 1'b0;
    release_o   = 1'b0;
    if (cur_cmd.valid) begin
      case (cur_cmd.word.f.op)
        OP_WRITE_LO: begin
          wr_d.valid = 1'b1;
        end
        OP_WRITE_HI: begin
          wr_d.valid = 1'b1;
          wr_d.hi    = 1'b1;
        end
        OP_READ: begin
          rd_en_o = 1'b1;
        end
        OP_HOLD_CORE: begin
          hold_o = 1'b1;
        end
        OP_RELEASE_CORE: begin
          release_o = 1'b1;
        end
        default: begin
          // Unknown opcodes are ignored
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    wr_q <= wr_d;
    if (reset_i) wr_q.valid <= 1'b0;
  end

  // Program memory is only writable while the core is held
  always_comb begin
    mem_wr_o       = wr_q;
    mem_wr_o.valid = wr_q.valid && core_reset_i;
  end

  // Memory answers one cycle after rd_en_o
  always_ff @(posedge clk) begin
    if (reset_i) begin
      rd_pend_q   <= 1'b0;
      read_data_o <= '0;
    end else begin
      rd_pend_q <= rd_en_o;
      if (rd_pend_q) read_data_o <= rd_data_i;
    end
  end

endmodule

/* source/program_memory.sv */
`timescale 1ns/1ps

module program_memory (
  input  logic                               clk,
  input  logic                               reset_i,
  input  harness_pkg::mem_wr_t               wr_i,
  input  logic                               rd_en_i,
  input  logic [harness_pkg::MEM_ADDR_W-1:0] rd_addr_i,
  output logic [31:0]                        rd_data_o,
  input  harness_pkg::wb_req_t               core_req_i,
  output harness_pkg::wb_rsp_t               core_rsp_o
);

  import harness_pkg::*;

  logic [31:0]           mem [MEM_WORDS];
  logic [MEM_ADDR_W-1:0] core_addr;
  logic                  core_req;
  logic                  core_wr;

  // Byte address from the core, word address into the array
  assign core_addr = core_req_i.addr[MEM_ADDR_W+1:2];

  // A request still open in its ack cycle is the same transfer
  assign core_req = core_req_i.cyc && core_req_i.stb && !core_rsp_o.ack;

  // Same-word collision goes to the controller
  assign core_wr = core_req && core_req_i.we &&
                   !(wr_i.valid && wr_i.addr == core_addr);

  always_ff @(posedge clk) begin
    if (core_wr) mem[core_addr] <= core_req_i.wdata;
    if (wr_i.valid) begin
      if (wr_i.hi) begin
        mem[wr_i.addr][31:16] <= wr_i.data16;
      end else begin
        mem[wr_i.addr][15:0] <= wr_i.data16;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en_i) rd_data_o <= mem[rd_addr_i];
  end

  always_ff @(posedge clk) begin
    if (core_req) core_rsp_o.rdata <= mem[core_addr];
    core_rsp_o.ack <= core_req;
    if (reset_i) core_rsp_o.ack <= 1'b0;
  end

endmodule

/* source/reset_sequencer.sv */
`timescale 1ns/1ps

module reset_sequencer (
  input  logic clk,
  input  logic reset_i,
  input  logic hold_i,
  input  logic release_i,
  output logic core_reset_o
);

  import harness_pkg::*;

  // Nonzero while a release is counting down
  logic [REL_CNT_W-1:0] cnt_q;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      core_reset_o <= 1'b1;
      cnt_q        <= '0;
    end else if (hold_i) begin
      // Hold wins and cancels any countdown
      core_reset_o <= 1'b1;
      cnt_q        <= '0;
    end else if (release_i) begin
      cnt_q <= REL_CNT_W'(RELEASE_CYCLES);
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
      if (cnt_q == REL_CNT_W'(1)) core_reset_o <= 1'b0;
    end
  end

endmodule

/* source/harness_top.sv */
`timescale 1ns/1ps

module harness_top (
  input  logic                 clk,
  input  logic                 reset_i,
  input  logic                 rx_i,
  input  logic                 sck_i,
  input  logic                 cs_i,
  input  logic                 mosi_i,
  output logic                 miso_o,
  input  harness_pkg::wb_req_t core_req_i,
  output harness_pkg::wb_rsp_t core_rsp_o,
  output logic                 core_reset_o
);

  import harness_pkg::*;

  cmd_strobe_t           uart_cmd;
  cmd_strobe_t           spi_cmd;
  mem_wr_t               mem_wr;
  logic                  rd_en;
  logic [MEM_ADDR_W-1:0] rd_addr;
  logic [31:0]           rd_data;
  logic [31:0]           read_data;
  logic                  core_hold;
  logic                  core_release;

  // Command links
  uart_cmd_rx uart_cmd_rx_inst (
    .clk     (clk),
    .reset_i (reset_i),
    .rx_i    (rx_i),
    .cmd_o   (uart_cmd)
  );

  spi_cmd_rx spi_cmd_rx_inst (
    .clk         (clk),
    .reset_i     (reset_i),
    .sck_i       (sck_i),
    .cs_i        (cs_i),
    .mosi_i      (mosi_i),
    .read_data_i (read_data),
    .miso_o      (miso_o),
    .cmd_o       (spi_cmd)
  );

  cmd_controller cmd_controller_inst (
    .clk          (clk),
    .reset_i      (reset_i),
    .uart_cmd_i   (uart_cmd),
    .spi_cmd_i    (spi_cmd),
    .core_reset_i (core_reset_o),
    .mem_wr_o     (mem_wr),
    .rd_en_o      (rd_en),
    .rd_addr_o    (rd_addr),
    .rd_data_i    (rd_data),
    .read_data_o  (read_data),
    .hold_o       (core_hold),
    .release_o    (core_release)
  );

  // Shared between the controller and the core bus
  program_memory program_memory_inst (
    .clk        (clk),
    .reset_i    (reset_i),
    .wr_i       (mem_wr),
    .rd_en_i    (rd_en),
    .rd_addr_i  (rd_addr),
    .rd_data_o  (rd_data),
    .core_req_i (core_req_i),
    .core_rsp_o (core_rsp_o)
  );

  reset_sequencer reset_sequencer_inst (
    .clk          (clk),
    .reset_i      (reset_i),
    .hold_i       (core_hold),
    .release_i    (core_release),
    .core_reset_o (core_reset_o)
  );

endmodule

/* sim/harness_sva.sv */
`timescale 1ns/1ps

module harness_sva (
  input logic                 clk,
  input logic                 reset_i,
  input harness_pkg::wb_req_t core_req_i,
  input harness_pkg::wb_rsp_t core_rsp_i,
  input harness_pkg::mem_wr_t mem_wr_i,
  input logic                 core_reset_i
);

  import harness_pkg::*;

  int   ack_late_fails = 0;
  int   ack_twice_fails = 0;
  int   ack_spurious_fails = 0;
  int   reset_fails = 0;
  int   write_fails = 0;
  int   fail_count;
  logic new_req;

  // New transfer, not the tail of one already acked
  assign new_req = core_req_i.cyc && core_req_i.stb && !core_rsp_i.ack;

  assign fail_count = ack_late_fails + ack_twice_fails + ack_spurious_fails +
                      reset_fails + write_fails;

  ack_follows_req: assert property (@(posedge clk) disable iff (reset_i)
    new_req |=> core_rsp_i.ack)
    else begin
      $error("core bus ack missing one cycle after request");
      ack_late_fails = ack_late_fails + 1;
    end

  ack_single: assert property (@(posedge clk) disable iff (reset_i)
    core_rsp_i.ack |=> !core_rsp_i.ack)
    else begin
      $error("core bus ack high for two cycles");
      ack_twice_fails = ack_twice_fails + 1;
    end

  ack_needs_req: assert property (@(posedge clk) disable iff (reset_i)
    core_rsp_i.ack |-> $past(new_req))
    else begin
      $error("core bus ack without a request");
      ack_spurious_fails = ack_spurious_fails + 1;
    end

  // Core stays held after a harness reset
  core_held_after_reset: assert property (@(posedge clk)
    reset_i |=> core_reset_i)
    else begin
      $error("core reset low in the cycle after reset");
      reset_fails = reset_fails + 1;
    end

  write_only_when_held: assert property (@(posedge clk) disable iff (reset_i)
    mem_wr_i.valid |-> core_reset_i)
    else begin
      $error("controller write while the core runs");
      write_fails = write_fails + 1;
    end

endmodule

bind harness_top harness_sva harness_sva_inst (
  .clk          (clk),
  .reset_i      (reset_i),
  .core_req_i   (core_req_i),
  .core_rsp_i   (core_rsp_o),
  .mem_wr_i     (mem_wr),
  .core_reset_i (core_reset_o)
);

/* sim/harness_tb.sv */
`timescale 1ns/1ps

module harness_tb;

  import harness_pkg::*;

  localparam int SCK_HALF = 4;
  localparam int UART_GAP = 2;
  localparam int UART_BYTE_CYCLES = 10 * CLKS_PER_BIT + UART_GAP;
  // Start edge of the last byte to its strobe
  localparam int UART_STROBE_LAT = 3 + CLKS_PER_BIT / 2 + 9 * CLKS_PER_BIT;
  localparam int SPI_STROBE_LAT = 3;
  localparam int SPI_CS_RISE = 66 * SCK_HALF;
  localparam int SPI_FRAME_CYCLES = 68 * SCK_HALF;
  localparam int COLLIDE_DELAY = 3 * UART_BYTE_CYCLES + UART_STROBE_LAT -
                                 SPI_STROBE_LAT - SPI_CS_RISE;
  localparam int ACK_LIMIT = 8;
  localparam int WATCHDOG_CYCLES = 10 + 9 * 4 * UART_BYTE_CYCLES + 6 * SPI_FRAME_CYCLES +
                                   2 * (RELEASE_CYCLES + 8) + 200;

  localparam logic [MEM_ADDR_W-1:0] ADDR_A = 12'h010;
  localparam logic [MEM_ADDR_W-1:0] ADDR_B = 12'h2a4;
  localparam logic [MEM_ADDR_W-1:0] ADDR_C = 12'h0c1;
  localparam logic [MEM_ADDR_W-1:0] ADDR_D = 12'h0c2;
  localparam logic [MEM_ADDR_W-1:0] ADDR_E = 12'hf3e;

  logic    clk;
  logic    reset;
  logic    rx;
  logic    sck;
  logic    cs;
  logic    mosi;
  logic    miso;
  wb_req_t core_req;
  wb_rsp_t core_rsp;
  logic    core_reset;
  int      errors = 0;
  int      collisions = 0;
  integer  seed = 32'ha994_076e;

  harness_top harness_top_inst (
    .clk          (clk),
    .reset_i      (reset),
    .rx_i         (rx),
    .sck_i        (sck),
    .cs_i         (cs),
    .mosi_i       (mosi),
    .miso_o       (miso),
    .core_req_i   (core_req),
    .core_rsp_o   (core_rsp),
    .core_reset_o (core_reset)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("TB FAILED");
    $finish;
  end

  // Both command strobes in one cycle
  always @(negedge clk) begin
    if (harness_top_inst.uart_cmd.valid && harness_top_inst.spi_cmd.valid) begin
      collisions = collisions + 1;
    end
  end

  function automatic logic [31:0] make_cmd(input cmd_op_e op,
                                           input logic [MEM_ADDR_W-1:0] addr,
                                           input logic [15:0] imm);
    return {op, addr, imm};
  endfunction

  task automatic check_word(input string test_name, input logic [31:0] exp,
                            input logic [31:0] act);
    assert (act === exp) else begin
      $display("ERR %s expected %h actual %h", test_name, exp, act);
      errors = errors + 1;
    end
  endtask

  // 8N1, bytes LSB first, low byte of the word first
  task automatic send_uart(input logic [31:0] word);
    logic [7:0] b;
    for (int k = 0; k < 4; k++) begin
      b = word[8*k +: 8];
      rx = 1'b0;
      repeat (CLKS_PER_BIT) @(negedge clk);
      for (int i = 0; i < 8; i++) begin
        rx = b[i];
        repeat (CLKS_PER_BIT) @(negedge clk);
      end
      rx = 1'b1;
      repeat (CLKS_PER_BIT + UART_GAP) @(negedge clk);
    end
  endtask

  // Mode 0, MSB first; MISO sampled just before each rising sck
  task automatic spi_frame(input logic [31:0] mosi_word, output logic [31:0] miso_word);
    cs = 1'b0;
    repeat (SCK_HALF) @(negedge clk);
    for (int i = 31; i >= 0; i--) begin
      mosi = mosi_word[i];
      repeat (SCK_HALF) @(negedge clk);
      miso_word[i] = miso;
      sck = 1'b1;
      repeat (SCK_HALF) @(negedge clk);
      sck = 1'b0;
    end
    repeat (SCK_HALF) @(negedge clk);
    cs = 1'b1;
    mosi = 1'b0;
    repeat (2 * SCK_HALF) @(negedge clk);
  endtask

  // SPI frame delayed so that both strobes land together
  task automatic send_both(input logic [31:0] uart_word, input logic [31:0] spi_word);
    logic [31:0] ignored;
    fork
      send_uart(uart_word);
      begin
        repeat (COLLIDE_DELAY) @(negedge clk);
        spi_frame(spi_word, ignored);
      end
    join
  endtask

  task automatic core_access(input logic we, input logic [MEM_ADDR_W-1:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
    int n;
    core_req.cyc = 1'b1;
    core_req.stb = 1'b1;
    core_req.we = we;
    core_req.addr = {{(30 - MEM_ADDR_W){1'b0}}, addr, 2'b00};
    core_req.wdata = wdata;
    n = 0;
    do begin
      @(negedge clk);
      n = n + 1;
    end while (!core_rsp.ack && n < ACK_LIMIT);
    if (!core_rsp.ack) begin
      $display("Core bus got no ack for word address %h", addr);
      errors = errors + 1;
    end
    rdata = core_rsp.rdata;
    // Request stays up through the ack cycle and must not be acked again
    @(negedge clk);
    core_req = '0;
  endtask

  task automatic wait_uart_strobe();
    int n;
    n = 0;
    while (!harness_top_inst.uart_cmd.valid && n < 4 * UART_BYTE_CYCLES + 16) begin
      @(negedge clk);
      n = n + 1;
    end
    if (!harness_top_inst.uart_cmd.valid) begin
      $display("UART command strobe never appeared");
      errors = errors + 1;
    end
  endtask

  task automatic wait_core_released();
    int n;
    n = 0;
    while (core_reset && n < 2 * RELEASE_CYCLES + 8) begin
      @(negedge clk);
      n = n + 1;
    end
    if (core_reset) begin
      $display("Core reset was never released");
      errors = errors + 1;
    end
  endtask

  initial begin
    logic [31:0] word_a;
    logic [31:0] word_b;
    logic [31:0] word_c;
    logic [31:0] word_d;
    logic [31:0] word_e;
    logic [31:0] rd_word;
    logic [31:0] miso_word;
    int          n;
    reset = 1'b1;
    rx = 1'b1;
    sck = 1'b0;
    cs = 1'b1;
    mosi = 1'b0;
    core_req = '0;
    repeat (10) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);

    // UART write pair, read back by the core
    check_word("held_after_reset", 32'd1, 32'(core_reset));
    word_a = $random(seed);
    send_uart(make_cmd(OP_WRITE_LO, ADDR_A, word_a[15:0]));
    send_uart(make_cmd(OP_WRITE_HI, ADDR_A, word_a[31:16]));
    core_access(1'b0, ADDR_A, 32'h0, rd_word);
    check_word("uart_write", word_a, rd_word);

    // SPI write pair, read out on MISO
    word_b = $random(seed);
    spi_frame(make_cmd(OP_WRITE_LO, ADDR_B, word_b[15:0]), miso_word);
    spi_frame(make_cmd(OP_WRITE_HI, ADDR_B, word_b[31:16]), miso_word);
    spi_frame(make_cmd(OP_READ, ADDR_B, 16'h0), miso_word);
    spi_frame(32'h0, miso_word);
    check_word("spi_read", word_b, miso_word);

    word_c = $random(seed);
    word_d = $random(seed);
    send_both(make_cmd(OP_WRITE_LO, ADDR_C, word_c[15:0]),
              make_cmd(OP_WRITE_LO, ADDR_D, word_d[15:0]));
    send_both(make_cmd(OP_WRITE_HI, ADDR_C, word_c[31:16]),
              make_cmd(OP_WRITE_HI, ADDR_D, word_d[31:16]));
    check_word("collision_count", 32'd2, 32'(collisions));
    core_access(1'b0, ADDR_C, 32'h0, rd_word);
    check_word("collide_uart", word_c, rd_word);
    core_access(1'b0, ADDR_D, 32'h0, rd_word);
    check_word("collide_spi", word_d, rd_word);

    // Release delay counted from the strobe cycle
    fork
      send_uart(make_cmd(OP_RELEASE_CORE, 12'h0, 16'h0));
      begin
        wait_uart_strobe();
        n = 0;
        do begin
          @(negedge clk);
          n = n + 1;
        end while (core_reset && n < 2 * RELEASE_CYCLES);
        check_word("release_delay", 32'(RELEASE_CYCLES + 1), 32'(n));
      end
    join
    send_uart(make_cmd(OP_HOLD_CORE, 12'h0, 16'h0));
    check_word("hold", 32'd1, 32'(core_reset));

    // Running core, write must be dropped
    send_uart(make_cmd(OP_RELEASE_CORE, 12'h0, 16'h0));
    wait_core_released();
    send_uart(make_cmd(OP_WRITE_LO, ADDR_A, ~word_a[15:0]));
    core_access(1'b0, ADDR_A, 32'h0, rd_word);
    check_word("dropped_write", word_a, rd_word);

    word_e = $random(seed);
    core_access(1'b1, ADDR_E, word_e, rd_word);
    spi_frame(make_cmd(OP_READ, ADDR_E, 16'h0), miso_word);
    spi_frame(32'h0, miso_word);
    check_word("core_write", word_e, miso_word);

    $display("Errors: %0d check, %0d assertion", errors,
             harness_top_inst.harness_sva_inst.fail_count);
    if (errors == 0 && harness_top_inst.harness_sva_inst.fail_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

/* all.f */
source/harness_pkg.sv
source/uart_cmd_rx.sv
source/spi_cmd_rx.sv
source/cmd_controller.sv
source/program_memory.sv
source/reset_sequencer.sv
source/harness_top.sv
sim/harness_sva.sv
sim/harness_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the harness testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f all.f \
  --top-module harness_tb -o harness_tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/harness_tb_sim +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TB FAILED" "$LOG"; then
  exit 1
fi
exit 0
